//--- logic/issue_pkg.sv
// Issue slice shared definitions
package issue_pkg;

	//----------------------------------------------------------------------
	// widths
	//----------------------------------------------------------------------
	localparam int NUM_THREADS = 4; // hardware threads sharing one issue slot
	localparam int THREAD_W = $clog2(NUM_THREADS);
	localparam int OPCODE_W = 3;
	localparam int DEST_W = 4;
	localparam int SRC_W = 8; // inline register-view operands
	localparam int IMM_W = 12; // immediate-view operand B
	localparam int RESULT_W = 16;

	localparam logic FMT_IMM = 1'b1; // format bit value selecting the immediate view

	//----------------------------------------------------------------------
	// scalar types
	//----------------------------------------------------------------------
	typedef logic [RESULT_W-1:0] result_t;
	typedef logic [DEST_W-1:0] dest_t;
	typedef logic [THREAD_W-1:0] thread_id_t;

	// mul and sqr take the multi-cycle path, everything else but nop is single cycle
	typedef enum logic [OPCODE_W-1:0]
	{
		OP_NOP = 3'd0,
		OP_ADD = 3'd1,
		OP_SUB = 3'd2,
		OP_AND = 3'd3,
		OP_OR = 3'd4,
		OP_XOR = 3'd5,
		OP_MUL = 3'd6,
		OP_SQR = 3'd7
	} opcode_e;

	//----------------------------------------------------------------------
	// instruction word, bit 31 picks which view applies
	//----------------------------------------------------------------------
	typedef struct packed
	{
		logic fmt; // bit 31
		opcode_e opcode; // bits 30..28
		dest_t dest; // bits 27..24
		logic [SRC_W-1:0] src_a; // bits 23..16
		logic [SRC_W-1:0] src_b; // bits 15..8
		logic [7:0] rsvd; // bits 7..0 carry nothing
	} inst_reg_t;

	typedef struct packed
	{
		logic fmt;
		opcode_e opcode;
		dest_t dest;
		logic [SRC_W-1:0] src_a;
		logic [IMM_W-1:0] imm12; // bits 15..4
		logic [3:0] rsvd;
	} inst_imm_t;

	typedef union packed
	{
		inst_reg_t reg_view;
		inst_imm_t imm_view;
	} inst_word_u;

endpackage

//--- logic/latency_decoder.sv
// Instruction latency classifier
`timescale 1ns/10ps

module latency_decoder
	import issue_pkg::*;
(
	input  inst_word_u inst_i,
	output logic       single_cycle_o,
	output logic       multi_cycle_o
);

	// opcode sits at the same bits in both views, so either view decodes it
	always_comb
	begin
		single_cycle_o = 1'b0;
		multi_cycle_o = 1'b0;
		case (inst_i.reg_view.opcode)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR:
			begin
				single_cycle_o = 1'b1; // result registered one cycle after issue
			end
			OP_MUL, OP_SQR:
			begin
				multi_cycle_o = 1'b1; // result leaves the multiply pipe
			end
			default:
			begin
				single_cycle_o = 1'b0; // nop and undecoded encodings write nothing back
				multi_cycle_o = 1'b0;
			end
		endcase
	end

endmodule

//--- logic/execute_hazard_detect.sv
// Writeback collision detector
`timescale 1ns/10ps

// The single and multi-cycle paths share one writeback port. A multi-cycle
// instruction issued in cycle c owns the port in cycle c+MULTI_LATENCY, so a
// single-cycle candidate issued in cycle c+MULTI_LATENCY-1 would collide.
module execute_hazard_detect
	import issue_pkg::*;
#(
	parameter int MULTI_LATENCY = 4
)
(
	input  logic                   clk,
	input  logic                   arst_n_i,
	input  inst_word_u             inst_i [NUM_THREADS],
	input  logic [NUM_THREADS-1:0] issue_i,
	output logic [NUM_THREADS-1:0] hazard_o
);

	logic [NUM_THREADS-1:0] single_cycle; // per candidate, from its decoder
	logic [NUM_THREADS-1:0] multi_cycle;
	logic issued_multi; // the instruction issued this cycle is multi cycle
	logic [MULTI_LATENCY-2:0] wb_alloc_q; // bit k: port taken MULTI_LATENCY-1-k cycles ahead

	//----------------------------------------------------------------------
	// per-thread decode of the candidate words
	//----------------------------------------------------------------------
	for (genvar n = 0; n < NUM_THREADS; n++)
	begin : g_decode
		latency_decoder u_latency_decoder
		(
			.inst_i         (inst_i[n]),
			.single_cycle_o (single_cycle[n]),
			.multi_cycle_o  (multi_cycle[n])
		);
	end

	// issue is one-hot, so masking and reducing picks the issued thread's flag
	always_comb
	begin
		issued_multi = |(issue_i & multi_cycle);
	end

	// the oldest slot means a multi-cycle result lands one cycle from now
	always_comb
	begin
		hazard_o = {NUM_THREADS{wb_alloc_q[MULTI_LATENCY-2]}} & single_cycle;
	end

	//----------------------------------------------------------------------
	// writeback allocation shift register
	//----------------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			wb_alloc_q <= '0;
		end
		else
		begin
			wb_alloc_q <= {wb_alloc_q[MULTI_LATENCY-3:0], issued_multi};
		end
	end

endmodule

//--- logic/thread_select.sv
// Round-robin thread selector
`timescale 1ns/10ps

module thread_select
	import issue_pkg::*;
(
	input  logic                   clk,
	input  logic                   arst_n_i,
	input  logic [NUM_THREADS-1:0] valid_i,
	input  logic [NUM_THREADS-1:0] hazard_i,
	output logic [NUM_THREADS-1:0] issue_o,
	output thread_id_t             issue_thread_o,
	output logic                   issue_valid_o
);

	logic [NUM_THREADS-1:0] ready; // valid and clear of a writeback collision
	logic [NUM_THREADS-1:0] ready_rot; // ready rotated so the pointer lands on bit 0
	thread_id_t offset; // distance of the winner from the pointer
	thread_id_t grant;
	logic found;
	thread_id_t rr_ptr_q; // highest-priority thread for the next choice

	always_comb
	begin
		ready = valid_i & ~hazard_i;
	end

	//----------------------------------------------------------------------
	// first ready thread at or after the pointer, wrapping around
	//----------------------------------------------------------------------
	always_comb
	begin
		ready_rot = NUM_THREADS'({ready, ready} >> rr_ptr_q);
		offset = '0;
		found = 1'b0;
		// walking down leaves the lowest ready offset as the winner
		for (int k = NUM_THREADS - 1; k >= 0; k--)
		begin
			if (ready_rot[k])
			begin
				offset = thread_id_t'(k);
				found = 1'b1;
			end
		end
		grant = rr_ptr_q + offset; // wraps modulo the thread count
	end

	always_comb
	begin
		issue_o = found ? (NUM_THREADS'(1) << grant) : '0;
		issue_thread_o = grant;
		issue_valid_o = found;
	end

	// the thread after the winner gets first claim next time
	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			rr_ptr_q <= '0;
		end
		else if (found)
		begin
			rr_ptr_q <= grant + thread_id_t'(1);
		end
	end

endmodule

//--- logic/execute_pipeline.sv
// Execute paths and writeback merge
`timescale 1ns/10ps

module execute_pipeline
	import issue_pkg::*;
#(
	parameter int MULTI_LATENCY = 4
)
(
	input  logic       clk,
	input  logic       arst_n_i,
	input  logic       issue_valid_i,
	input  thread_id_t issue_thread_i,
	input  inst_word_u inst_i,
	output logic       wb_valid_o,
	output thread_id_t wb_thread_o,
	output dest_t      wb_dest_o,
	output result_t    wb_result_o
);

	logic single_cycle;
	logic multi_cycle;
	result_t op_a;
	result_t op_b;
	result_t alu_result;
	result_t mul_result;

	// single-cycle stage
	logic sc_valid_q;
	thread_id_t sc_thread_q;
	dest_t sc_dest_q;
	result_t sc_result_q;

	// multiply pipe, stage MULTI_LATENCY-1 is the one that writes back
	logic [MULTI_LATENCY-1:0] mc_valid_q;
	thread_id_t mc_thread_q [MULTI_LATENCY];
	dest_t mc_dest_q [MULTI_LATENCY];
	result_t mc_prod_q [MULTI_LATENCY];

	latency_decoder u_latency_decoder
	(
		.inst_i         (inst_i),
		.single_cycle_o (single_cycle),
		.multi_cycle_o  (multi_cycle)
	);

	//----------------------------------------------------------------------
	// operand decode and arithmetic
	//----------------------------------------------------------------------
	always_comb
	begin
		op_a = result_t'(inst_i.reg_view.src_a);
		if (inst_i.reg_view.fmt == FMT_IMM)
			op_b = result_t'(inst_i.imm_view.imm12);
		else
			op_b = result_t'(inst_i.reg_view.src_b);
	end

	always_comb
	begin
		case (inst_i.reg_view.opcode)
			OP_ADD: alu_result = op_a + op_b;
			OP_SUB: alu_result = op_a - op_b;
			OP_AND: alu_result = op_a & op_b;
			OP_OR: alu_result = op_a | op_b;
			OP_XOR: alu_result = op_a ^ op_b;
			default: alu_result = '0;
		endcase
	end

	// low half of the product is all that is written back
	always_comb
	begin
		mul_result = (inst_i.reg_view.opcode == OP_SQR) ? op_a * op_a : op_a * op_b;
	end

	//----------------------------------------------------------------------
	// valid bits
	//----------------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			sc_valid_q <= 1'b0;
			mc_valid_q <= '0;
		end
		else
		begin
			sc_valid_q <= issue_valid_i & single_cycle;
			mc_valid_q <= {mc_valid_q[MULTI_LATENCY-2:0], issue_valid_i & multi_cycle};
		end
	end

	// payload follows its valid bit down the stages
	always_ff @(posedge clk)
	begin
		if (issue_valid_i)
		begin
			sc_thread_q <= issue_thread_i;
			sc_dest_q <= inst_i.reg_view.dest;
			sc_result_q <= alu_result;
		end
		mc_thread_q[0] <= issue_thread_i;
		mc_dest_q[0] <= inst_i.reg_view.dest;
		mc_prod_q[0] <= mul_result;
		for (int k = 1; k < MULTI_LATENCY; k++)
		begin
			mc_thread_q[k] <= mc_thread_q[k-1];
			mc_dest_q[k] <= mc_dest_q[k-1];
			mc_prod_q[k] <= mc_prod_q[k-1];
		end
	end

	//----------------------------------------------------------------------
	// writeback mux, the hazard detector keeps the two stages apart
	//----------------------------------------------------------------------
	always_comb
	begin
		wb_valid_o = mc_valid_q[MULTI_LATENCY-1] | sc_valid_q;
		if (mc_valid_q[MULTI_LATENCY-1])
		begin
			wb_thread_o = mc_thread_q[MULTI_LATENCY-1];
			wb_dest_o = mc_dest_q[MULTI_LATENCY-1];
			wb_result_o = mc_prod_q[MULTI_LATENCY-1];
		end
		else
		begin
			wb_thread_o = sc_thread_q;
			wb_dest_o = sc_dest_q;
			wb_result_o = sc_result_q;
		end
	end

endmodule

//--- logic/issue_execute_top.sv
// Issue and execute slice top level
`timescale 1ns/10ps

// MULTI_LATENCY must be at least 3 for the hazard shift register to exist
module issue_execute_top
	import issue_pkg::*;
#(
	parameter int MULTI_LATENCY = 4
)
(
	input  logic                   clk,
	input  logic                   arst_n_i,
	input  inst_word_u             inst_i [NUM_THREADS],
	input  logic [NUM_THREADS-1:0] inst_valid_i,
	output logic [NUM_THREADS-1:0] issue_o,
	output logic                   wb_valid_o,
	output thread_id_t             wb_thread_o,
	output dest_t                  wb_dest_o,
	output result_t                wb_result_o
);

	logic [NUM_THREADS-1:0] hazard; // per thread, would collide at writeback
	logic [NUM_THREADS-1:0] issue; // one-hot accept strobe, also fed back to the detector
	thread_id_t issue_thread;
	logic issue_valid;
	inst_word_u issue_inst; // word of the thread chosen this cycle

	execute_hazard_detect #(
		.MULTI_LATENCY (MULTI_LATENCY)
	) u_execute_hazard_detect (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.inst_i   (inst_i),
		.issue_i  (issue),
		.hazard_o (hazard)
	);

	thread_select u_thread_select
	(
		.clk            (clk),
		.arst_n_i       (arst_n_i),
		.valid_i        (inst_valid_i),
		.hazard_i       (hazard),
		.issue_o        (issue),
		.issue_thread_o (issue_thread),
		.issue_valid_o  (issue_valid)
	);

	// word select by the granted thread index
	always_comb
	begin
		issue_inst = inst_i[issue_thread];
	end

	execute_pipeline #(
		.MULTI_LATENCY (MULTI_LATENCY)
	) u_execute_pipeline (
		.clk            (clk),
		.arst_n_i       (arst_n_i),
		.issue_valid_i  (issue_valid),
		.issue_thread_i (issue_thread),
		.inst_i         (issue_inst),
		.wb_valid_o     (wb_valid_o),
		.wb_thread_o    (wb_thread_o),
		.wb_dest_o      (wb_dest_o),
		.wb_result_o    (wb_result_o)
	);

	assign issue_o = issue;

endmodule

//--- verification/tb_model.svh
// Reference model and result checks

localparam int DUE_W = 32;
localparam int ENTRY_W = DUE_W + DEST_W + RESULT_W; // due cycle, dest, result

logic [ENTRY_W-1:0] exp_q [NUM_THREADS][$]; // expected writebacks of each thread
logic [MULTI_LATENCY-2:0] multi_hist = '0; // bit k set: multi-cycle issue k+1 cycles ago
int issue_idx = 0; // counts issues while fairness is watched
int last_idx [NUM_THREADS];
logic fair_on = 1'b0;

//----------------------------------------------------------------------
// compare tasks
//----------------------------------------------------------------------
task automatic check_result(input result_t got, input result_t exp);
	if (got !== exp)
	begin
		err_count++;
		$display("mismatch at %0t: result %h, expected %h", $time, got, exp);
	end
endtask

task automatic check_dest(input dest_t got, input dest_t exp);
	if (got !== exp)
	begin
		err_count++;
		$display("mismatch at %0t: dest %h, expected %h", $time, got, exp);
	end
endtask

task automatic check_thread(input thread_id_t got, input thread_id_t exp);
	if (got !== exp)
	begin
		err_count++;
		$display("mismatch at %0t: thread %0d, expected %0d", $time, got, exp);
	end
endtask

//----------------------------------------------------------------------
// instruction rules
//----------------------------------------------------------------------
function automatic result_t expected_result(input logic [31:0] raw);
	result_t a;
	result_t b;
	a = result_t'(raw[23:16]);
	b = raw[31] ? result_t'(raw[15:4]) : result_t'(raw[15:8]); // immediate view when set
	case (opcode_e'(raw[30:28]))
		OP_ADD: return a + b;
		OP_SUB: return a - b;
		OP_AND: return a & b;
		OP_OR: return a | b;
		OP_XOR: return a ^ b;
		OP_MUL: return a * b;
		OP_SQR: return a * a;
		default: return '0;
	endcase
endfunction

// cycles from issue to writeback, zero when nothing is written back
function automatic int latency_of(input logic [31:0] raw);
	case (opcode_e'(raw[30:28]))
		OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: return 1;
		OP_MUL, OP_SQR: return MULTI_LATENCY;
		default: return 0;
	endcase
endfunction

//----------------------------------------------------------------------
// model updates, called once per cycle at the falling edge
//----------------------------------------------------------------------
task automatic model_issue(input int now);
	int t;
	int lat;
	logic [31:0] raw;
	t = -1;
	lat = 0;
	if ($countones(issue_o) > 1)
	begin
		err_count++;
		$display("error at %0t: more than one issue strobe high", $time);
	end
	for (int n = 0; n < NUM_THREADS; n++)
		if (issue_o[n])
			t = n;
	if (t >= 0)
	begin
		raw = inst_i[t];
		lat = latency_of(raw);
		if (lat == 1 && multi_hist[MULTI_LATENCY-2]) // would share writeback with a multiply
		begin
			err_count++;
			$display("error at %0t: single-cycle issue collides with a multiply", $time);
		end
		if (lat != 0)
			exp_q[t].push_back({DUE_W'(now + lat), dest_t'(raw[27:24]), expected_result(raw)});
		if (fair_on)
		begin
			if (issue_idx - last_idx[t] > NUM_THREADS)
			begin
				err_count++;
				$display("error at %0t: thread %0d waited more than four issues", $time, t);
			end
			last_idx[t] = issue_idx;
			issue_idx++;
		end
	end
	multi_hist = {multi_hist[MULTI_LATENCY-3:0], (t >= 0 && lat == MULTI_LATENCY)};
endtask

task automatic check_writeback(input int now);
	int hits;
	int found_t;
	int i;
	logic [ENTRY_W-1:0] e;
	logic [ENTRY_W-1:0] found_e;
	hits = 0;
	found_t = 0;
	found_e = '0;
	for (int n = 0; n < NUM_THREADS; n++)
	begin
		i = 0;
		while (i < exp_q[n].size())
		begin
			e = exp_q[n][i];
			if (int'(e[ENTRY_W-1 -: DUE_W]) == now)
			begin
				hits++;
				found_e = e;
				found_t = n;
				exp_q[n].delete(i);
			end
			else
				i++;
		end
	end
	if (hits > 1)
	begin
		err_count++;
		$display("error at %0t: two results due in the same cycle", $time);
	end
	if (wb_valid_o !== 1'b0 && hits == 0)
	begin
		err_count++;
		$display("error at %0t: writeback with no expected result", $time);
	end
	else if (wb_valid_o === 1'b1)
	begin
		check_thread(wb_thread_o, thread_id_t'(found_t));
		check_dest(wb_dest_o, found_e[RESULT_W +: DEST_W]);
		check_result(wb_result_o, found_e[RESULT_W-1:0]);
	end
	else if (hits > 0)
	begin
		err_count++;
		$display("error at %0t: expected writeback missing in cycle %0d", $time, now);
	end
endtask

function automatic logic model_empty();
	for (int n = 0; n < NUM_THREADS; n++)
		if (exp_q[n].size() != 0)
			return 1'b0;
	return 1'b1;
endfunction

task automatic fair_start();
	fair_on = 1'b1;
	for (int n = 0; n < NUM_THREADS; n++)
		last_idx[n] = issue_idx;
endtask

task automatic fair_final();
	for (int n = 0; n < NUM_THREADS; n++)
		if (issue_idx - last_idx[n] > NUM_THREADS)
		begin
			err_count++;
			$display("error at %0t: thread %0d not issued in the last window", $time, n);
		end
	fair_on = 1'b0;
endtask

//--- verification/tb_issue_execute.sv
// Issue and execute testbench
`timescale 1ns/10ps

module tb_issue_execute;
	import issue_pkg::*;

	localparam int MULTI_LATENCY = 4;
	localparam int RESET_CYCLES = 10;
	localparam int TEST_CYCLES = 200; // stimulus cycles per test
	localparam int DRAIN_CYCLES = 40; // pending issues plus the multiply pipe
	localparam int NUM_TESTS = 5;
	localparam int CYCLE_LIMIT = RESET_CYCLES + 4 + NUM_TESTS * (TEST_CYCLES + DRAIN_CYCLES) + 50;

	// opcode mixes for the generator
	localparam int MODE_ALU = 0;
	localparam int MODE_MUL = 1;
	localparam int MODE_MIX = 2;
	localparam int MODE_NOP_ALU = 3;

	logic clk;
	logic arst_n_i;
	inst_word_u inst_i [NUM_THREADS];
	logic [NUM_THREADS-1:0] inst_valid_i;
	logic [NUM_THREADS-1:0] issue_o;
	logic wb_valid_o;
	thread_id_t wb_thread_o;
	dest_t wb_dest_o;
	result_t wb_result_o;

	logic [15:0] lfsr_q;
	int cyc;
	int err_count;
	int tests_passed;
	int tests_failed;
	logic gen_on; // new instructions are presented
	logic hold_all; // every thread valid whenever it can be
	int gen_mode;
	logic [NUM_THREADS-1:0] issued_seen; // issue strobes seen in the current cycle

	`include "tb_model.svh"

	issue_execute_top #(
		.MULTI_LATENCY (MULTI_LATENCY)
	) u_dut (
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.inst_i       (inst_i),
		.inst_valid_i (inst_valid_i),
		.issue_o      (issue_o),
		.wb_valid_o   (wb_valid_o),
		.wb_thread_o  (wb_thread_o),
		.wb_dest_o    (wb_dest_o),
		.wb_result_o  (wb_result_o)
	);

	always
	begin
		#20 clk = ~clk;
	end

	//----------------------------------------------------------------------
	// random source, x^16 + x^14 + x^13 + x^11
	//----------------------------------------------------------------------
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic fb;
		v = '0;
		for (int k = 0; k < n; k++)
		begin
			fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
			lfsr_q = {lfsr_q[14:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic inst_word_u make_word(input int mode);
		logic [31:0] raw;
		logic [2:0] op;
		raw = rand_bits(32);
		case (mode)
			MODE_ALU: op = 3'(rand_bits(3) % 5) + 3'(OP_ADD);
			MODE_MUL: op = rand_bits(1) ? 3'(OP_MUL) : 3'(OP_SQR);
			MODE_NOP_ALU: op = rand_bits(1) ? 3'(OP_NOP) : 3'(rand_bits(3) % 5) + 3'(OP_ADD);
			default: op = 3'(rand_bits(3));
		endcase
		raw[30:28] = op;
		return inst_word_u'(raw);
	endfunction

	// a thread holds its word until it is issued, then moves on or drops valid
	always @(posedge clk)
	begin
		for (int n = 0; n < NUM_THREADS; n++)
		begin
			if (!inst_valid_i[n] || issued_seen[n])
			begin
				if (gen_on && (hold_all || rand_bits(1) == 1))
				begin
					inst_i[n] <= make_word(gen_mode);
					inst_valid_i[n] <= 1'b1;
				end
				else
					inst_valid_i[n] <= 1'b0;
			end
		end
	end

	// outputs are settled by the falling edge
	always @(negedge clk)
	begin
		if (arst_n_i)
		begin
			check_writeback(cyc);
			model_issue(cyc);
			issued_seen = issue_o;
		end
		else
		begin
			issued_seen = '0;
			if (issue_o !== '0 || wb_valid_o !== 1'b0)
			begin
				err_count++;
				$display("error at %0t: issue or writeback active during reset", $time);
			end
		end
	end

	always @(posedge clk)
	begin
		cyc <= cyc + 1;
		if (cyc >= CYCLE_LIMIT)
		begin
			$display("timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Simulation failed");
			$finish;
		end
	end

	//----------------------------------------------------------------------
	// test sequencing
	//----------------------------------------------------------------------
	task automatic report_test(input string name, input int err_start);
		if (err_count == err_start)
		begin
			tests_passed++;
			$display("test %s: passed", name);
		end
		else
		begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, err_count - err_start);
		end
	endtask

	task automatic run_test(input string name, input int mode, input logic all_valid,
		input logic fair);
		int err_start;
		err_start = err_count;
		@(negedge clk);
		gen_mode = mode;
		hold_all = all_valid;
		if (fair)
			fair_start();
		gen_on = 1'b1;
		repeat (TEST_CYCLES) @(negedge clk);
		gen_on = 1'b0;
		@(posedge clk);
		if (fair)
			fair_final();
		while (inst_valid_i != '0 || !model_empty())
			@(posedge clk);
		report_test(name, err_start);
	endtask

	initial
	begin
		int err_start;
		clk = 1'b0;
		arst_n_i = 1'b0;
		inst_valid_i = '0;
		for (int n = 0; n < NUM_THREADS; n++)
			inst_i[n] = '0;
		lfsr_q = 16'd9;
		cyc = 0;
		err_count = 0;
		tests_passed = 0;
		tests_failed = 0;
		gen_on = 1'b0;
		hold_all = 1'b0;
		gen_mode = MODE_ALU;
		issued_seen = '0;

		err_start = err_count;
		repeat (RESET_CYCLES) @(posedge clk);
		arst_n_i <= 1'b1;
		repeat (2)
		begin
			@(negedge clk);
			if (issue_o !== '0 || wb_valid_o !== 1'b0)
			begin
				err_count++;
				$display("error at %0t: issue or writeback active after reset", $time);
			end
		end
		report_test("reset state", err_start);

		run_test("single-cycle results", MODE_ALU, 1'b0, 1'b0);
		run_test("multi-cycle results", MODE_MUL, 1'b0, 1'b0);
		run_test("mixed traffic", MODE_MIX, 1'b0, 1'b0);
		run_test("hazard avoidance", MODE_MIX, 1'b1, 1'b0); // all threads busy, many hazards
		run_test("no-result opcodes and fairness", MODE_NOP_ALU, 1'b1, 1'b1);

		$display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed,
			err_count);
		if (tests_failed == 0 && err_count == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- all.f
+incdir+verification
logic/issue_pkg.sv
logic/latency_decoder.sv
logic/execute_hazard_detect.sv
logic/thread_select.sv
logic/execute_pipeline.sv
logic/issue_execute_top.sv
verification/tb_issue_execute.sv
